// File: cam_pipe_defs.svh
`ifndef CAM_PIPE_DEFS_SVH
`define CAM_PIPE_DEFS_SVH

// component width of raw and colour samples
`define CAM_PIX_BITS            10

// stream FIFO depth is 2**CAM_FIFO_PTR_BITS
`define CAM_FIFO_PTR_BITS       4

// identification word
`define CAM_ID_VALUE            32'h01234567

// --------------------
// register word map
`define CAM_ADDR_ID             3'd0
`define CAM_ADDR_SW_RESET       3'd1
`define CAM_ADDR_CAM_ENABLE     3'd2
`define CAM_ADDR_FMT_SELECT     3'd3
`define CAM_ADDR_FRAME_COUNT    3'd4

`endif

// File: cam_pipe_pkg.sv
`include "cam_pipe_defs.svh"

package cam_pipe_pkg;

    // --------------------
    // pixel path
    typedef logic [`CAM_PIX_BITS-1:0]   pix_comp_t;     // one raw or colour sample
    typedef logic [4*`CAM_PIX_BITS-1:0] pix_word_t;     // {raw, r, g, b}
    typedef logic [31:0]                mem_word_t;     // packed memory word

    // --------------------
    // register path
    typedef logic [2:0]                 reg_addr_t;     // word address
    typedef logic [31:0]                reg_data_t;
    typedef logic [2:0]                 fmt_sel_t;      // output format select
    typedef logic [7:0]                 frame_cnt_t;    // wraps at 256

endpackage

// File: cam_ctrl_regs.sv
`timescale 1ns/1ns
`include "cam_pipe_defs.svh"

module cam_ctrl_regs
    import cam_pipe_pkg::*;
(
    input  logic       axi4s_cam_aclk,
    input  logic       sys_reset,

    input  logic       reg_wr_i,
    input  logic       reg_rd_i,
    input  reg_addr_t  reg_addr_i,
    input  reg_data_t  reg_wdata_i,
    output reg_data_t  reg_rdata_o,
    output logic       reg_rvalid_o,

    input  logic       frame_start_i,   // accepted start-of-frame beat

    output logic       sw_reset_o,
    output logic       cam_enable_o,
    output fmt_sel_t   fmt_select_o
);

    logic       reg_sw_reset;
    logic       reg_cam_enable;
    fmt_sel_t   reg_fmt_select;
    frame_cnt_t reg_frame_count;
    reg_data_t  rd_mux;

    // --------------------
    // write side
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_sw_reset   <= 1'b0;
            reg_cam_enable <= 1'b0;
            reg_fmt_select <= '0;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                `CAM_ADDR_SW_RESET:   reg_sw_reset   <= reg_wdata_i[0];
                `CAM_ADDR_CAM_ENABLE: reg_cam_enable <= reg_wdata_i[0];
                `CAM_ADDR_FMT_SELECT: reg_fmt_select <= fmt_sel_t'(reg_wdata_i);
                default: ;  // id, counter and holes are read only
            endcase
        end
    end

    // frame counter, not touched by software reset
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_frame_count <= '0;
        end else if (frame_start_i) begin
            reg_frame_count <= reg_frame_count + 1'b1;
        end
    end

    // --------------------
    // read side
    always_comb begin
        case (reg_addr_i)
            `CAM_ADDR_ID:          rd_mux = `CAM_ID_VALUE;
            `CAM_ADDR_SW_RESET:    rd_mux = reg_data_t'(reg_sw_reset);
            `CAM_ADDR_CAM_ENABLE:  rd_mux = reg_data_t'(reg_cam_enable);
            `CAM_ADDR_FMT_SELECT:  rd_mux = reg_data_t'(reg_fmt_select);
            `CAM_ADDR_FRAME_COUNT: rd_mux = reg_data_t'(reg_frame_count);
            default:               rd_mux = '0;
        endcase
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= reg_rd_i;   // one cycle pulse per strobe
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (reg_rd_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    assign sw_reset_o   = reg_sw_reset;
    assign cam_enable_o = reg_cam_enable;
    assign fmt_select_o = reg_fmt_select;

    // read data only ever follows a strobe by one cycle
    a_rvalid_after_rd : assert property (
        @(posedge axi4s_cam_aclk) disable iff (sys_reset)
        reg_rvalid_o |-> $past(reg_rd_i)
    );

endmodule

// File: pixel_fifo.sv
`timescale 1ns/1ns
`include "cam_pipe_defs.svh"

module pixel_fifo
    import cam_pipe_pkg::*;
#(
    parameter int PTR_BITS = `CAM_FIFO_PTR_BITS
)
(
    input  logic       axi4s_cam_aclk,
    input  logic       sys_reset,
    input  logic       flush_i,

    input  logic       s_valid_i,
    input  pix_word_t  s_data_i,
    input  logic       s_user_i,    // start of frame
    input  logic       s_last_i,    // end of line
    output logic       s_ready_o,

    output logic       m_valid_o,
    output pix_word_t  m_data_o,
    output logic       m_user_o,
    output logic       m_last_o,
    input  logic       m_ready_i
);

    localparam int DEPTH = 1 << PTR_BITS;

    // pixel and both flags kept side by side
    typedef struct packed {
        pix_word_t data;
        logic      user;
        logic      last;
    } entry_t;

    entry_t              mem [DEPTH];
    entry_t              rd_entry;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;     // one extra bit to tell full from empty
    logic                push;
    logic                pop;

    assign s_ready_o = (count != (PTR_BITS+1)'(DEPTH));
    assign m_valid_o = (count != '0);

    assign push = s_valid_i && s_ready_o;
    assign pop  = m_valid_o && m_ready_i;

    // --------------------
    // storage
    always_ff @(posedge axi4s_cam_aclk) begin
        if (push) begin
            mem[wr_ptr] <= '{data: s_data_i, user: s_user_i, last: s_last_i};
        end
    end

    assign rd_entry = mem[rd_ptr];
    assign m_data_o = rd_entry.data;
    assign m_user_o = rd_entry.user;
    assign m_last_o = rd_entry.last;

    // --------------------
    // pointers and occupancy
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                  // both or neither
            endcase
        end
    end

    a_no_overfill : assert property (
        @(posedge axi4s_cam_aclk) disable iff (sys_reset)
        count <= (PTR_BITS+1)'(DEPTH)
    );

endmodule

// File: pixel_packer.sv
`timescale 1ns/1ns
`include "cam_pipe_defs.svh"

module pixel_packer
    import cam_pipe_pkg::*;
(
    input  logic       axi4s_cam_aclk,
    input  logic       sys_reset,
    input  logic       flush_i,
    input  fmt_sel_t   fmt_select_i,

    input  logic       s_valid_i,
    input  pix_word_t  s_data_i,
    input  logic       s_user_i,
    input  logic       s_last_i,
    output logic       s_ready_o,

    output logic       m_valid_o,
    output mem_word_t  m_data_o,
    output logic       m_user_o,
    output logic       m_last_o,
    input  logic       m_ready_i
);

    logic accept;

    // one developed pixel into a 32 bit memory word
    function automatic mem_word_t pack_pixel(input pix_word_t pix, input fmt_sel_t fmt);
        pix_comp_t raw;
        pix_comp_t r;
        pix_comp_t g;
        pix_comp_t b;
        mem_word_t w;
        raw = pix[4*`CAM_PIX_BITS-1:3*`CAM_PIX_BITS];
        r   = pix[3*`CAM_PIX_BITS-1:2*`CAM_PIX_BITS];
        g   = pix[2*`CAM_PIX_BITS-1:`CAM_PIX_BITS];
        b   = pix[`CAM_PIX_BITS-1:0];
        w   = '0;
        case (fmt)
            3'd0: w = {raw[9:2], r[9:2], g[9:2], b[9:2]};   // 8bit BGRx
            3'd1: w = {raw[9:2], b[9:2], g[9:2], r[9:2]};   // 8bit RGBx
            3'd2: w[9:0] = raw;                             // raw 10
            3'd3: w[15:0] = {raw, raw[9:4]};                // raw 16, msbs repeated
            3'd4: w[29:0] = {r, g, b};                      // B10G10R10
            3'd5: w[29:0] = {b, g, r};                      // R10G10B10
            default: ;                                      // reserved, zero
        endcase
        return w;
    endfunction

    // output register free, or being drained this cycle
    assign s_ready_o = !m_valid_o || m_ready_i;
    assign accept    = s_valid_i && s_ready_o;

    // --------------------
    // output register
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || flush_i) begin
            m_valid_o <= 1'b0;
        end else if (accept) begin
            m_valid_o <= 1'b1;
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (accept) begin
            m_data_o <= pack_pixel(s_data_i, fmt_select_i);
            m_user_o <= s_user_i;
            m_last_o <= s_last_i;
        end
    end

    // held beat must not change under back-pressure
    a_hold_stable : assert property (
        @(posedge axi4s_cam_aclk) disable iff (sys_reset)
        (m_valid_o && !m_ready_i) |=> $stable({m_data_o, m_user_o, m_last_o})
    );

endmodule

// File: cam_pipe_top.sv
`timescale 1ns/1ns
`include "cam_pipe_defs.svh"

module cam_pipe_top
    import cam_pipe_pkg::*;
(
    input  logic       axi4s_cam_aclk,
    input  logic       sys_reset,

    // register port
    input  logic       reg_wr_i,
    input  logic       reg_rd_i,
    input  reg_addr_t  reg_addr_i,
    input  reg_data_t  reg_wdata_i,
    output reg_data_t  reg_rdata_o,
    output logic       reg_rvalid_o,
    output logic       cam_enable_o,

    // developed pixel stream in
    input  logic       s_tvalid_i,
    input  pix_word_t  s_tdata_i,
    input  logic       s_tuser_i,
    input  logic       s_tlast_i,
    output logic       s_tready_o,

    // packed stream out
    output logic       m_tvalid_o,
    output mem_word_t  m_tdata_o,
    output logic       m_tuser_o,
    output logic       m_tlast_o,
    input  logic       m_tready_i
);

    logic      sw_reset;
    fmt_sel_t  fmt_select;
    logic      frame_start;
    logic      fifo_in_valid;
    logic      fifo_in_ready;
    logic      fifo_valid;
    pix_word_t fifo_data;
    logic      fifo_user;
    logic      fifo_last;
    logic      fifo_ready;

    // --------------------
    // input gating
    assign s_tready_o    = fifo_in_ready && !sw_reset;  // closed during sw reset
    assign fifo_in_valid = s_tvalid_i && !sw_reset;
    assign frame_start   = s_tvalid_i && s_tready_o && s_tuser_i;

    cam_ctrl_regs u_ctrl_regs (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .reg_wr_i       (reg_wr_i),
        .reg_rd_i       (reg_rd_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .reg_rvalid_o   (reg_rvalid_o),
        .frame_start_i  (frame_start),
        .sw_reset_o     (sw_reset),
        .cam_enable_o   (cam_enable_o),
        .fmt_select_o   (fmt_select)
    );

    pixel_fifo #(
        .PTR_BITS (`CAM_FIFO_PTR_BITS)
    ) u_pixel_fifo (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .flush_i        (sw_reset),
        .s_valid_i      (fifo_in_valid),
        .s_data_i       (s_tdata_i),
        .s_user_i       (s_tuser_i),
        .s_last_i       (s_tlast_i),
        .s_ready_o      (fifo_in_ready),
        .m_valid_o      (fifo_valid),
        .m_data_o       (fifo_data),
        .m_user_o       (fifo_user),
        .m_last_o       (fifo_last),
        .m_ready_i      (fifo_ready)
    );

    pixel_packer u_pixel_packer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .flush_i        (sw_reset),
        .fmt_select_i   (fmt_select),
        .s_valid_i      (fifo_valid),
        .s_data_i       (fifo_data),
        .s_user_i       (fifo_user),
        .s_last_i       (fifo_last),
        .s_ready_o      (fifo_ready),
        .m_valid_o      (m_tvalid_o),
        .m_data_o       (m_tdata_o),
        .m_user_o       (m_tuser_o),
        .m_last_o       (m_tlast_o),
        .m_ready_i      (m_tready_i)
    );

endmodule

// File: tb_cam_pipe.sv
`timescale 1ns/1ns
`include "cam_pipe_defs.svh"

module tb_cam_pipe
    import cam_pipe_pkg::*;
();

    localparam int BEATS_PER_FMT   = 200;
    localparam int FLUSH_BEATS     = 10;    // parked in the pipe, then dropped
    localparam int AFTER_BEATS     = 40;
    localparam int TOTAL_BEATS     = 8*BEATS_PER_FMT + FLUSH_BEATS + AFTER_BEATS;
    localparam int WATCHDOG_CYCLES = 20*TOTAL_BEATS;

    logic       axi4s_cam_aclk;
    logic       sys_reset;
    logic       reg_wr;
    logic       reg_rd;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    logic       reg_rvalid;
    logic       cam_enable;
    logic       s_tvalid;
    pix_word_t  s_tdata;
    logic       s_tuser;
    logic       s_tlast;
    logic       s_tready;
    logic       m_tvalid;
    mem_word_t  m_tdata;
    logic       m_tuser;
    logic       m_tlast;
    logic       m_tready;

    integer      seed = 87;
    int          error_count = 0;
    int          check_count = 0;
    int          start_count = 0;   // accepted start-of-frame beats
    fmt_sel_t    cur_fmt = '0;
    logic [33:0] expect_q[$];       // {user, last, word}
    logic [33:0] exp_beat;
    reg_data_t   exp_regs [8];

    cam_pipe_top dut0 (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .reg_wr_i       (reg_wr),
        .reg_rd_i       (reg_rd),
        .reg_addr_i     (reg_addr),
        .reg_wdata_i    (reg_wdata),
        .reg_rdata_o    (reg_rdata),
        .reg_rvalid_o   (reg_rvalid),
        .cam_enable_o   (cam_enable),
        .s_tvalid_i     (s_tvalid),
        .s_tdata_i      (s_tdata),
        .s_tuser_i      (s_tuser),
        .s_tlast_i      (s_tlast),
        .s_tready_o     (s_tready),
        .m_tvalid_o     (m_tvalid),
        .m_tdata_o      (m_tdata),
        .m_tuser_o      (m_tuser),
        .m_tlast_o      (m_tlast),
        .m_tready_i     (m_tready)
    );

    always #5 axi4s_cam_aclk = !axi4s_cam_aclk;

    // expected memory word, built from shifted components
    function automatic mem_word_t pack_expected(input pix_word_t pix, input fmt_sel_t fmt);
        mem_word_t raw;
        mem_word_t r;
        mem_word_t g;
        mem_word_t b;
        mem_word_t w;
        raw = {22'd0, pix[39:30]};
        r   = {22'd0, pix[29:20]};
        g   = {22'd0, pix[19:10]};
        b   = {22'd0, pix[9:0]};
        case (fmt)
            3'd0:    w = ((raw >> 2) << 24) | ((r >> 2) << 16) | ((g >> 2) << 8) | (b >> 2);
            3'd1:    w = ((raw >> 2) << 24) | ((b >> 2) << 16) | ((g >> 2) << 8) | (r >> 2);
            3'd2:    w = raw;
            3'd3:    w = (raw << 6) | (raw >> 4);
            3'd4:    w = (r << 20) | (g << 10) | b;
            3'd5:    w = (b << 20) | (g << 10) | r;
            default: w = '0;
        endcase
        return w;
    endfunction

    // --------------------
    // register access
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge axi4s_cam_aclk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge axi4s_cam_aclk);
        #1;
        reg_wr    = 1'b0;
    endtask

    task automatic check_read(input reg_addr_t addr, input reg_data_t expected);
        @(posedge axi4s_cam_aclk);
        #1;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge axi4s_cam_aclk);
        #1;
        reg_rd   = 1'b0;
        @(negedge axi4s_cam_aclk);
        check_count++;
        if (!reg_rvalid) begin
            $display("register read of address %0d never returned read valid", addr);
            error_count++;
        end else if (reg_rdata !== expected) begin
            $display("Fail at %0t: address %0d read %h, expected %h",
                     $time, addr, reg_rdata, expected);
            error_count++;
        end
        @(negedge axi4s_cam_aclk);
        if (reg_rvalid) begin
            $display("read valid of address %0d stayed high for more than one cycle", addr);
            error_count++;
        end
    endtask

    task automatic set_format(input fmt_sel_t fmt);
        reg_write(`CAM_ADDR_FMT_SELECT, reg_data_t'(fmt));
        cur_fmt = fmt;
    endtask

    // --------------------
    // stream traffic
    task automatic send_beats(input int n, input bit track, input bit vary_ready);
        int          sent;
        bit          take;
        logic [31:0] lo;
        logic [31:0] hi;
        sent = 0;
        while (sent < n) begin
            @(negedge axi4s_cam_aclk);
            take = s_tvalid && s_tready;    // handshake at the coming edge
            if (take) begin
                if (track) begin
                    expect_q.push_back({s_tuser, s_tlast, pack_expected(s_tdata, cur_fmt)});
                end
                if (s_tuser) begin
                    start_count++;
                end
                sent++;
            end
            @(posedge axi4s_cam_aclk);
            #1;
            if (vary_ready) begin
                m_tready = (($random(seed) & 3) != 0);
            end
            if (take || !s_tvalid) begin
                if (sent < n && (($random(seed) & 3) != 0)) begin
                    lo       = $random(seed);
                    hi       = $random(seed);
                    s_tdata  = {hi[7:0], lo};
                    s_tuser  = (hi[31:29] == 3'b000);   // about one in eight
                    s_tlast  = (hi[28:27] == 2'b00);
                    s_tvalid = 1'b1;
                end else begin
                    s_tvalid = 1'b0;
                end
            end
        end
    endtask

    task automatic drain_output();
        s_tvalid = 1'b0;
        m_tready = 1'b1;
        while (expect_q.size() != 0) begin
            @(negedge axi4s_cam_aclk);
        end
    endtask

    // output monitor against the model queue
    always @(negedge axi4s_cam_aclk) begin
        if (!sys_reset && m_tvalid && m_tready) begin
            if (expect_q.size() == 0) begin
                $display("output beat at %0t arrived with no input beat left to match", $time);
                error_count++;
            end else begin
                exp_beat = expect_q.pop_front();
                check_count++;
                if ({m_tuser, m_tlast, m_tdata} !== exp_beat) begin
                    $display("Fail at %0t: output user %b last %b data %h, expected %b %b %h",
                             $time, m_tuser, m_tlast, m_tdata,
                             exp_beat[33], exp_beat[32], exp_beat[31:0]);
                    error_count++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axi4s_cam_aclk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        axi4s_cam_aclk = 1'b0;
        sys_reset      = 1'b1;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        s_tvalid       = 1'b0;
        s_tdata        = '0;
        s_tuser        = 1'b0;
        s_tlast        = 1'b0;
        m_tready       = 1'b0;
        repeat (10) @(posedge axi4s_cam_aclk);
        #1;
        sys_reset = 1'b0;

        // --------------------
        // reset values
        @(negedge axi4s_cam_aclk);
        check_count++;
        if (cam_enable !== 1'b0 || m_tvalid !== 1'b0 || s_tready !== 1'b1) begin
            $display("Fail at %0t: after reset enable %b out valid %b in ready %b",
                     $time, cam_enable, m_tvalid, s_tready);
            error_count++;
        end
        exp_regs[0] = `CAM_ID_VALUE;
        for (int a = 1; a < 8; a++) begin
            exp_regs[a] = '0;
        end
        for (int a = 0; a < 5; a++) begin
            check_read(reg_addr_t'(a), exp_regs[a]);
        end

        // --------------------
        // register write and read back
        for (int a = 1; a < 4; a++) begin
            rnd = $random(seed);
            reg_write(reg_addr_t'(a), rnd);
            exp_regs[a] = (a == 3) ? (rnd & 32'h7) : (rnd & 32'h1);
            check_read(reg_addr_t'(a), exp_regs[a]);
        end
        check_count++;
        if (cam_enable !== exp_regs[2][0]) begin
            $display("Fail at %0t: cam enable %b, expected %b", $time, cam_enable, exp_regs[2][0]);
            error_count++;
        end
        exp_regs[2] = exp_regs[2] ^ 32'h1;  // other enable level
        reg_write(`CAM_ADDR_CAM_ENABLE, exp_regs[2]);
        check_count++;
        if (cam_enable !== exp_regs[2][0]) begin
            $display("Fail at %0t: cam enable %b, expected %b", $time, cam_enable, exp_regs[2][0]);
            error_count++;
        end
        reg_write(`CAM_ADDR_ID, $random(seed));     // read only and holes
        for (int a = 4; a < 8; a++) begin
            reg_write(reg_addr_t'(a), $random(seed));
        end
        for (int a = 0; a < 8; a++) begin
            check_read(reg_addr_t'(a), exp_regs[a]);
        end
        reg_write(`CAM_ADDR_SW_RESET, '0);

        // --------------------
        // random traffic in every format
        for (int f = 0; f < 8; f++) begin
            set_format(fmt_sel_t'(f));
            send_beats(BEATS_PER_FMT, 1'b1, 1'b1);
            drain_output();
        end
        check_read(`CAM_ADDR_FRAME_COUNT, reg_data_t'(start_count & 255));

        // --------------------
        // software reset with beats parked in the pipe
        rnd = $random(seed);
        set_format(rnd[2:0]);
        m_tready = 1'b0;
        send_beats(FLUSH_BEATS, 1'b0, 1'b0);
        reg_write(`CAM_ADDR_SW_RESET, 32'd1);
        @(negedge axi4s_cam_aclk);
        check_count++;
        if (s_tready !== 1'b0) begin
            $display("Fail at %0t: during sw reset in ready %b, expected 0", $time, s_tready);
            error_count++;
        end
        @(negedge axi4s_cam_aclk);
        check_count++;
        if (m_tvalid !== 1'b0) begin
            $display("Fail at %0t: out valid %b after a cycle of sw reset, expected 0",
                     $time, m_tvalid);
            error_count++;
        end
        reg_write(`CAM_ADDR_SW_RESET, '0);
        m_tready = 1'b1;
        repeat (20) begin
            @(negedge axi4s_cam_aclk);
            if (m_tvalid) begin
                $display("Fail at %0t: flushed beat still left the pipeline", $time);
                error_count++;
            end
        end
        @(posedge axi4s_cam_aclk);
        #1;
        send_beats(AFTER_BEATS, 1'b1, 1'b1);
        drain_output();

        repeat (4) @(posedge axi4s_cam_aclk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: cam_pipe_top.f
+incdir+.
cam_pipe_pkg.sv
cam_ctrl_regs.sv
pixel_fifo.sv
pixel_packer.sv
cam_pipe_top.sv
tb_cam_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_cam_pipe -f cam_pipe_top.f \
    && ./obj_dir/Vtb_cam_pipe > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
